// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := vex_datapath_tb
FILELIST  := vex_datapath.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/vex_ctrl_pkg.sv ====
`include "vex_settings.svh"

package vex_ctrl_pkg;
    import vex_types_pkg::*;

    // per-lane alu operation
    typedef enum logic [2:0] {
        VALU_ADD = 3'd0,
        VALU_SUB = 3'd1,
        VALU_AND = 3'd2,
        VALU_OR  = 3'd3,
        VALU_XOR = 3'd4,
        VALU_SEQ = 3'd5
    } valuop_t;

    // functional unit select
    typedef enum logic [1:0] {
        VFU_ALU = 2'd0,
        VFU_RED = 2'd1,
        VFU_MSK = 2'd2
    } vfu_t;

    // issued micro-op
    typedef struct packed {
        logic      vvalid;
        vfu_t      vfu;
        valuop_t   valuop;
        sew_t      vsew;
        vreg_idx_t vs1_sel;
        vreg_idx_t vs2_sel;
        vreg_idx_t vd_sel;
        logic      vmask_en;
        logic      vxin1_use_imm;
        // sign-extended before use
        logic [4:0] vimm;
        logic      vregwen;
    } vcontrol_t;

    // write-back into the lane banks
    typedef struct packed {
        logic                                          vwen;
        vreg_idx_t                                     vd;
        lanes_t                                        vwdata;
        logic [`VEX_NUM_LANES-1:0][`VEX_WORD_W/8-1:0]  vbyte_wen;
    } vwb_t;

    // execute to memory stage register
    typedef struct packed {
        logic                      vvalid;
        logic                      vregwen;
        vreg_idx_t                 vd_sel;
        sew_t                      vsew;
        lanes_t                    vres;
        logic [`VEX_NUM_LANES-1:0] vlane_mask;
    } vexmem_t;

endpackage

// ==== hw/vex_datapath.sv ====
`timescale 1ns/1ps
`include "vex_settings.svh"

module vex_datapath (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  vex_ctrl_pkg::vcontrol_t  vctrls,
    input  vex_ctrl_pkg::vwb_t       vwb_ctrls,
    input  logic                     ex_mem_stall,
    input  vex_types_pkg::word_t     vl,
    output vex_ctrl_pkg::vexmem_t    vmem_in,
    output logic                     vex_stall
);
    import vex_types_pkg::*;
    import vex_ctrl_pkg::*;

    lanes_t  bank_rd1;
    lanes_t  bank_rd2;
    lanes_t  bank_rd3;
    lanes_t  v0;
    lanes_t  vop_a;
    lanes_t  vop_b;
    lanes_t  alu_res;
    word_t   ext_imm;
    word_t   red_sum;
    word_t   mc_count;
    vexmem_t vmem_next;
    logic [`VEX_NUM_LANES-1:0] lane_mask;
    logic    alu_fire;
    logic    mc_start;
    logic    mc_busy;
    logic    mc_done;

    assign ext_imm = {{(`VEX_WORD_W-5){vctrls.vimm[4]}}, vctrls.vimm};

    // vs2 is operand A, vs1 or the immediate is operand B
    assign vop_a = bank_rd2;
    assign vop_b = vctrls.vxin1_use_imm ? {`VEX_NUM_LANES{ext_imm}} : bank_rd1;

    // lane enable from bit 0 of each lane's v0 word
    always_comb begin
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            lane_mask[i] = vctrls.vmask_en ? v0[i][0] : 1'b1;
        end
    end

    for (genvar ln = 0; ln < `VEX_NUM_LANES; ln++) begin : g_lane
        // third port feeds the mask unit with the vcpop source
        vex_vector_bank u_bank (
            .CLK      (CLK),
            .rst_n    (rst_n),
            .vs1      (vctrls.vs1_sel),
            .vs2      (vctrls.vs2_sel),
            .vs3      (vctrls.vs2_sel),
            .vw       (vwb_ctrls.vd),
            .wen      (vwb_ctrls.vwen),
            .byte_wen (vwb_ctrls.vbyte_wen[ln]),
            .vwdata   (vwb_ctrls.vwdata[ln]),
            .vdat1    (bank_rd1[ln]),
            .vdat2    (bank_rd2[ln]),
            .vdat3    (bank_rd3[ln]),
            .v0       (v0[ln])
        );

        vex_lane_alu u_alu (
            .vop_a  (vop_a[ln]),
            .vop_b  (vop_b[ln]),
            .valuop (vctrls.valuop),
            .vsew   (vctrls.vsew),
            .vres   (alu_res[ln])
        );
    end

    vex_reduction_unit u_red (
        .vdat  (vop_a),
        .vmask (lane_mask),
        .vsum  (red_sum)
    );

    assign mc_start = vctrls.vvalid && (vctrls.vfu == VFU_MSK);

    vex_mask_calc_fsm u_mask_calc (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .start    (mc_start),
        .hold     (ex_mem_stall),
        .mask_src (bank_rd3),
        .v0_mask  (v0),
        .mask_en  (vctrls.vmask_en),
        .vl       (vl),
        .busy     (mc_busy),
        .done     (mc_done),
        .count    (mc_count)
    );

    assign vex_stall = mc_busy;

    // single-cycle ops issue only when nothing upstream or downstream blocks
    assign alu_fire = vctrls.vvalid && (vctrls.vfu != VFU_MSK) && !ex_mem_stall && !mc_busy;

    always_comb begin
        vmem_next         = vmem_in;
        vmem_next.vvalid  = 1'b0;
        vmem_next.vregwen = 1'b0;
        if (mc_done || alu_fire) begin
            vmem_next.vvalid  = 1'b1;
            vmem_next.vregwen = vctrls.vregwen;
            vmem_next.vd_sel  = vctrls.vd_sel;
            vmem_next.vsew    = vctrls.vsew;
            vmem_next.vres    = '0;
            vmem_next.vlane_mask = 4'b0001;
            if (mc_done) begin
                vmem_next.vres[0] = mc_count;
            end else begin
                case (vctrls.vfu)
                    VFU_ALU: begin
                        vmem_next.vres       = alu_res;
                        vmem_next.vlane_mask = lane_mask;
                    end
                    VFU_RED: begin
                        vmem_next.vres[0] = red_sum;
                    end
                    default: begin
                        vmem_next.vvalid  = 1'b0;
                        vmem_next.vregwen = 1'b0;
                    end
                endcase
            end
        end
    end

    // output holds while the memory stage is stalled
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            vmem_in <= '0;
        end else if (!ex_mem_stall) begin
            vmem_in <= vmem_next;
        end
    end

endmodule

// ==== hw/vex_lane_alu.sv ====
`timescale 1ns/1ps

module vex_lane_alu (
    input  vex_types_pkg::word_t    vop_a,
    input  vex_types_pkg::word_t    vop_b,
    input  vex_ctrl_pkg::valuop_t   valuop,
    input  vex_types_pkg::sew_t     vsew,
    output vex_types_pkg::word_t    vres
);
    import vex_types_pkg::*;
    import vex_ctrl_pkg::*;

    lane_word_u a_u;
    lane_word_u b_u;
    lane_word_u r_u;

    // one element, zero-extended into a word; emask trims to element width
    function automatic word_t elem_op(input word_t x, input word_t y, input word_t emask,
                                      input valuop_t op);
        word_t r;
        case (op)
            VALU_ADD: r = x + y;
            VALU_SUB: r = x - y;
            VALU_AND: r = x & y;
            VALU_OR:  r = x | y;
            VALU_XOR: r = x ^ y;
            VALU_SEQ: r = (((x ^ y) & emask) == '0) ? emask : '0;
            default:  r = '0;
        endcase
        return r & emask;
    endfunction

    assign a_u.w = vop_a;
    assign b_u.w = vop_b;

    // carries stop at element edges since each element is trimmed on its own
    always_comb begin
        word_t tmp;
        r_u.w = '0;
        tmp   = '0;
        case (vsew)
            SEW8: begin
                for (int i = 0; i < 4; i++) begin
                    tmp = elem_op({24'd0, a_u.b[i]}, {24'd0, b_u.b[i]}, 32'h0000_00ff, valuop);
                    r_u.b[i] = tmp[7:0];
                end
            end
            SEW16: begin
                for (int i = 0; i < 2; i++) begin
                    tmp = elem_op({16'd0, a_u.h[i]}, {16'd0, b_u.h[i]}, 32'h0000_ffff, valuop);
                    r_u.h[i] = tmp[15:0];
                end
            end
            SEW32: begin
                r_u.w = elem_op(a_u.w, b_u.w, '1, valuop);
            end
            default: begin
                r_u.w = '0;
            end
        endcase
    end

    assign vres = r_u.w;

endmodule

// ==== hw/vex_mask_calc_fsm.sv ====
`timescale 1ns/1ps

module vex_mask_calc_fsm (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  hold,
    input  logic [127:0]          mask_src,
    input  logic [127:0]          v0_mask,
    input  logic                  mask_en,
    input  vex_types_pkg::word_t  vl,
    output logic                  busy,
    output logic                  done,
    output vex_types_pkg::word_t  count
);
    import vex_types_pkg::*;

    typedef enum logic [1:0] {IDLE, SCAN, DONE} state_t;

    state_t     state;
    state_t     state_next;
    logic [3:0] chunk;
    logic       last;
    logic       accept;
    logic       scanning;
    logic       advance;
    logic [7:0] chunk_src;
    logic [7:0] chunk_v0;
    word_t      chunk_base;
    word_t      pop;
    word_t      acc_q;

    // a new scan can begin from IDLE or straight out of DONE
    assign accept   = start && !hold && (state != SCAN);
    assign scanning = accept || (state == SCAN);
    assign advance  = scanning && !hold;
    assign busy     = scanning;
    assign done     = advance && last;

    vex_scan_counter u_scan_counter (
        .CLK   (CLK),
        .rst_n (rst_n),
        .clear (done),
        .step  (advance && !last),
        .vl    (vl),
        .chunk (chunk),
        .last  (last)
    );

    assign chunk_base = {25'd0, chunk, 3'b000};
    assign chunk_src  = mask_src[{chunk, 3'b000} +: 8];
    assign chunk_v0   = v0_mask[{chunk, 3'b000} +: 8];

    // bits at or past vl never count
    always_comb begin
        pop = '0;
        for (int j = 0; j < 8; j++) begin
            if (chunk_src[j] && (!mask_en || chunk_v0[j]) && ((chunk_base + word_t'(j)) < vl)) begin
                pop = pop + 32'd1;
            end
        end
    end

    // running total including this cycle's chunk
    assign count = (accept ? '0 : acc_q) + (scanning ? pop : '0);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            state <= IDLE;
        end else begin
            state <= state_next;
            if (advance) begin
                acc_q <= count;
            end
        end
    end

    always_comb begin
        case (state)
            IDLE, DONE: state_next = accept ? (done ? DONE : SCAN) : IDLE;
            SCAN:       state_next = done ? DONE : SCAN;
            default:    state_next = IDLE;
        endcase
    end

endmodule

// ==== hw/vex_reduction_unit.sv ====
`timescale 1ns/1ps
`include "vex_settings.svh"

module vex_reduction_unit (
    input  vex_types_pkg::lanes_t       vdat,
    input  logic [`VEX_NUM_LANES-1:0]   vmask,
    output vex_types_pkg::word_t        vsum
);
    import vex_types_pkg::*;

    lane_word_u [`VEX_NUM_LANES-1:0] gated;

    // masked lanes contribute zero
    always_comb begin
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            gated[i].w = vmask[i] ? vdat[i] : '0;
        end
    end

    // full 32-bit sum, wraps mod 2^32
    always_comb begin
        vsum = '0;
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            vsum = vsum + gated[i].w;
        end
    end

endmodule

// ==== hw/vex_scan_counter.sv ====
`timescale 1ns/1ps

module vex_scan_counter (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  step,
    input  vex_types_pkg::word_t  vl,
    output logic [3:0]            chunk,
    output logic                  last
);
    import vex_types_pkg::*;

    // one past the top bit index of the current chunk
    word_t chunk_end;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            chunk <= '0;
        end else if (clear) begin
            chunk <= '0;
        end else if (step) begin
            chunk <= chunk + 4'd1;
        end
    end

    assign chunk_end = {25'd0, chunk, 3'b111} + 32'd1;

    // chunk 15 is the end of the 128-bit mask whatever vl says
    assign last = (chunk_end >= vl) || (chunk == 4'hf);

endmodule

// ==== hw/vex_types_pkg.sv ====
`include "vex_settings.svh"

package vex_types_pkg;

    // one lane word
    typedef logic [`VEX_WORD_W-1:0] word_t;

    // vector register index
    typedef logic [$clog2(`VEX_NUM_VREGS)-1:0] vreg_idx_t;

    // element width
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    // one word per lane, lane 0 in the low bits
    typedef word_t [`VEX_NUM_LANES-1:0] lanes_t;

    // same lane word seen at each element width
    typedef union packed {
        word_t                                w;
        logic [`VEX_WORD_W/16-1:0][15:0]      h;
        logic [`VEX_WORD_W/8-1:0][7:0]        b;
    } lane_word_u;

endpackage

// ==== hw/vex_vector_bank.sv ====
`timescale 1ns/1ps
`include "vex_settings.svh"

module vex_vector_bank (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  vex_types_pkg::vreg_idx_t  vs1,
    input  vex_types_pkg::vreg_idx_t  vs2,
    input  vex_types_pkg::vreg_idx_t  vs3,
    input  vex_types_pkg::vreg_idx_t  vw,
    input  logic                      wen,
    input  logic [`VEX_WORD_W/8-1:0]  byte_wen,
    input  vex_types_pkg::word_t      vwdata,
    output vex_types_pkg::word_t      vdat1,
    output vex_types_pkg::word_t      vdat2,
    output vex_types_pkg::word_t      vdat3,
    output vex_types_pkg::word_t      v0
);
    import vex_types_pkg::*;

    word_t regs [`VEX_NUM_VREGS];

    // only the enabled bytes of the target word change
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `VEX_NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wen) begin
            for (int b = 0; b < `VEX_WORD_W/8; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][b*8 +: 8] <= vwdata[b*8 +: 8];
                end
            end
        end
    end

    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];
    assign vdat3 = regs[vs3];

    // v0 is this lane's slice of the mask register
    assign v0 = regs[0];

endmodule

// ==== include/vex_settings.svh ====
`ifndef VEX_SETTINGS_SVH
`define VEX_SETTINGS_SVH

// lanes in the execute stage
`define VEX_NUM_LANES 4

// bits per lane word
`define VEX_WORD_W 32

// vector registers held in each lane bank
`define VEX_NUM_VREGS 8

`endif

// ==== verification/vex_datapath_asserts.sv ====
`timescale 1ns/1ps

module vex_datapath_asserts (
    input logic                  CLK,
    input logic                  rst_n,
    input logic                  ex_mem_stall,
    input logic                  vex_stall,
    input vex_ctrl_pkg::vexmem_t vmem_in
);
    // consecutive sampled cycles with vex_stall high
    int unsigned stall_run;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            stall_run <= 0;
        end else if (vex_stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    a_quiet_after_reset: assert property (@(posedge CLK)
        $rose(rst_n) |-> (!vex_stall && !vmem_in.vvalid))
        else $error("vex_stall or vmem_in.vvalid high right after reset");

    a_hold_under_stall: assert property (@(posedge CLK) disable iff (!rst_n)
        ex_mem_stall |=> $stable(vmem_in))
        else $error("vmem_in changed while ex_mem_stall was high");

    // longest scan is 16 chunks of 8 bits
    a_stall_bounded: assert property (@(posedge CLK) disable iff (!rst_n)
        stall_run <= 16)
        else $error("vex_stall high for more than 16 cycles");

endmodule

// ==== verification/vex_datapath_tb.sv ====
`timescale 1ns/1ps
`include "vex_settings.svh"

module vex_datapath_tb;
    import vex_types_pkg::*;
    import vex_ctrl_pkg::*;

    localparam int RESET_CYCLES = 4;
    // per test: writes plus issue cycles, vcpop dominates
    localparam int TEST_CYCLES  = 5 + 11 + 4 + 3 + 6 * 18 + 7;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + TEST_CYCLES);

    logic      CLK;
    logic      rst_n;
    vcontrol_t vctrls;
    vwb_t      vwb_ctrls;
    logic      ex_mem_stall;
    word_t     vl;
    vexmem_t   vmem_in;
    logic      vex_stall;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycle_count;

    vex_datapath u_dut (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .vctrls       (vctrls),
        .vwb_ctrls    (vwb_ctrls),
        .ex_mem_stall (ex_mem_stall),
        .vl           (vl),
        .vmem_in      (vmem_in),
        .vex_stall    (vex_stall)
    );

    bind vex_datapath vex_datapath_asserts u_asserts (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .ex_mem_stall (ex_mem_stall),
        .vex_stall    (vex_stall),
        .vmem_in      (vmem_in)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic word_t random_word();
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic lanes_t random_lanes();
        lanes_t l;
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            l[i] = random_word();
        end
        return l;
    endfunction

    // element-wise result, each element wraps at its own width
    function automatic word_t alu_model(input valuop_t op, input sew_t sew,
                                        input word_t a, input word_t b);
        int          w;
        logic [63:0] m;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] er;
        word_t       res;
        w   = (sew == SEW8) ? 8 : ((sew == SEW16) ? 16 : 32);
        m   = (64'd1 << w) - 64'd1;
        res = '0;
        for (int i = 0; i < 32 / w; i++) begin
            ea = (64'(a) >> (i * w)) & m;
            eb = (64'(b) >> (i * w)) & m;
            case (op)
                VALU_ADD: er = ea + eb;
                VALU_SUB: er = ea - eb;
                VALU_AND: er = ea & eb;
                VALU_OR:  er = ea | eb;
                VALU_XOR: er = ea ^ eb;
                VALU_SEQ: er = (ea == eb) ? m : 64'd0;
                default:  er = 64'd0;
            endcase
            res = res | word_t'((er & m) << (i * w));
        end
        return res;
    endfunction

    function automatic lanes_t alu_lanes_model(input valuop_t op, input sew_t sew,
                                               input lanes_t a, input lanes_t b);
        lanes_t r;
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            r[i] = alu_model(op, sew, a[i], b[i]);
        end
        return r;
    endfunction

    function automatic word_t sum_model(input lanes_t src, input logic [3:0] mask);
        word_t s;
        s = '0;
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            if (mask[i]) begin
                s = s + src[i];
            end
        end
        return s;
    endfunction

    // mask bit i sits in lane i/32 at position i mod 32
    function automatic word_t popcount_model(input lanes_t src, input lanes_t m0,
                                             input logic mask_en, input word_t vl_val);
        word_t n;
        n = '0;
        for (int i = 0; i < 128; i++) begin
            if ((i < vl_val) && src[i / 32][i % 32] && (!mask_en || m0[i / 32][i % 32])) begin
                n = n + 32'd1;
            end
        end
        return n;
    endfunction

    function automatic vcontrol_t make_ctrl(input vfu_t fu, input valuop_t op, input sew_t sew,
                                            input vreg_idx_t vs1, input vreg_idx_t vs2,
                                            input logic mask_en);
        vcontrol_t c;
        c          = '0;
        c.vvalid   = 1'b1;
        c.vfu      = fu;
        c.valuop   = op;
        c.vsew     = sew;
        c.vs1_sel  = vs1;
        c.vs2_sel  = vs2;
        c.vd_sel   = 3'd2;
        c.vmask_en = mask_en;
        c.vregwen  = 1'b1;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_result(input string name, input vexmem_t res, input lanes_t exp_res,
                                  input logic [3:0] exp_mask);
        check_value({name, " vvalid"}, 160'(1'b1), 160'(res.vvalid));
        check_value({name, " vres"}, 160'(exp_res), 160'(res.vres));
        check_value({name, " lane mask"}, 160'(exp_mask), 160'(res.vlane_mask));
    endtask

    // all tasks start and end 2 ns after a rising edge
    task automatic write_reg(input vreg_idx_t rd, input lanes_t data);
        vwb_ctrls.vwen      = 1'b1;
        vwb_ctrls.vd        = rd;
        vwb_ctrls.vwdata    = data;
        vwb_ctrls.vbyte_wen = '1;
        @(posedge CLK);
        #2;
        vwb_ctrls.vwen = 1'b0;
    endtask

    // single-cycle op lands in vmem_in on the issue edge
    task automatic run_op(input vcontrol_t c, output vexmem_t res);
        vctrls = c;
        @(posedge CLK);
        #1;
        res = vmem_in;
        #1;
        vctrls = '0;
    endtask

    task automatic write_read_back();
        lanes_t    w1;
        lanes_t    w2;
        vcontrol_t c;
        vexmem_t   res;
        w1 = random_lanes();
        w2 = random_lanes();
        write_reg(3'd1, w1);
        write_reg(3'd2, w2);
        c = make_ctrl(VFU_ALU, VALU_ADD, SEW32, 3'd0, 3'd1, 1'b0);
        c.vxin1_use_imm = 1'b1;
        c.vimm          = 5'd0;
        run_op(c, res);
        compare_result("readback v1", res, w1, 4'hf);
        check_value("readback vd_sel", 160'(3'd2), 160'(res.vd_sel));
        check_value("readback vregwen", 160'(1'b1), 160'(res.vregwen));
        c.vs2_sel = 3'd2;
        run_op(c, res);
        compare_result("readback v2", res, w2, 4'hf);
        // -5 must win over the v1 operand and reach every lane sign-extended
        c.vs1_sel = 3'd1;
        c.vimm    = 5'h1b;
        c.vregwen = 1'b0;
        run_op(c, res);
        compare_result("negative imm", res,
                       alu_lanes_model(VALU_ADD, SEW32, w2, {`VEX_NUM_LANES{32'hffff_fffb}}),
                       4'hf);
        check_value("negative imm vregwen", 160'(1'b0), 160'(res.vregwen));
    endtask

    task automatic elem_width_ops();
        lanes_t    a;
        lanes_t    b;
        lanes_t    b_eq;
        vexmem_t   res;
        sew_t      sews [2];
        valuop_t   ops [3];
        lanes_t    flips;
        sews  = '{SEW8, SEW16};
        ops   = '{VALU_ADD, VALU_SUB, VALU_XOR};
        flips = {32'hff00_00ff, 32'h00ff_0000, 32'h0000_ff00, 32'h0000_0000};
        // top bit of every byte set so sums carry out of each element
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            a[i]    = random_word() | 32'h8080_8080;
            b[i]    = random_word() | 32'h8080_8080;
            b_eq[i] = a[i] ^ flips[i];
        end
        write_reg(3'd4, a);
        write_reg(3'd5, b);
        write_reg(3'd6, b_eq);
        for (int s = 0; s < 2; s++) begin
            for (int j = 0; j < 3; j++) begin
                run_op(make_ctrl(VFU_ALU, ops[j], sews[s], 3'd5, 3'd4, 1'b0), res);
                compare_result($sformatf("%s %s", ops[j].name(), sews[s].name()), res,
                               alu_lanes_model(ops[j], sews[s], a, b), 4'hf);
            end
            run_op(make_ctrl(VFU_ALU, VALU_SEQ, sews[s], 3'd6, 3'd4, 1'b0), res);
            compare_result($sformatf("VALU_SEQ %s", sews[s].name()), res,
                           alu_lanes_model(VALU_SEQ, sews[s], a, b_eq), 4'hf);
            check_value($sformatf("VALU_SEQ %s vsew", sews[s].name()), 160'(sews[s]),
                        160'(res.vsew));
        end
    endtask

    task automatic masked_add();
        lanes_t  a;
        lanes_t  b;
        lanes_t  m0;
        vexmem_t res;
        a = random_lanes();
        b = random_lanes();
        // v0 low bit set in lanes 1 and 3 only
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            m0[i] = (random_word() & 32'hffff_fffe) | ((i % 2 == 1) ? 32'h1 : 32'h0);
        end
        write_reg(3'd4, a);
        write_reg(3'd5, b);
        write_reg(3'd0, m0);
        run_op(make_ctrl(VFU_ALU, VALU_ADD, SEW32, 3'd5, 3'd4, 1'b1), res);
        compare_result("masked add", res, alu_lanes_model(VALU_ADD, SEW32, a, b), 4'b1010);
    endtask

    task automatic masked_sum();
        lanes_t     src;
        lanes_t     m0;
        lanes_t     exp;
        logic [3:0] mask;
        vexmem_t    res;
        src = random_lanes();
        m0  = random_lanes();
        write_reg(3'd7, src);
        write_reg(3'd0, m0);
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            mask[i] = m0[i][0];
        end
        exp    = '0;
        exp[0] = sum_model(src, mask);
        run_op(make_ctrl(VFU_RED, VALU_ADD, SEW32, 3'd0, 3'd7, 1'b1), res);
        compare_result("masked sum", res, exp, 4'b0001);
    endtask

    task automatic mask_popcount();
        word_t   vls [3];
        lanes_t  src;
        lanes_t  m0;
        lanes_t  exp;
        vexmem_t res;
        int      edges;
        int      gaps;
        string   name;
        vls = '{32'd1, 32'd37, 32'd128};
        for (int k = 0; k < 3; k++) begin
            for (int me = 0; me < 2; me++) begin
                name = $sformatf("vcpop vl=%0d mask_en=%0d", vls[k], me);
                src  = random_lanes();
                m0   = random_lanes();
                vl   = vls[k];
                write_reg(3'd3, src);
                write_reg(3'd0, m0);
                vctrls = make_ctrl(VFU_MSK, VALU_ADD, SEW32, 3'd0, 3'd3, me[0]);
                #1;
                if (!vex_stall) begin
                    errors++;
                    $display("%s: vex_stall did not rise in the issue cycle", name);
                end
                edges = 0;
                gaps  = 0;
                // count edges until the result is registered
                do begin
                    @(posedge CLK);
                    #1;
                    edges++;
                    if (!vmem_in.vvalid && !vex_stall) begin
                        gaps++;
                    end
                end while (!vmem_in.vvalid && edges < 20);
                res = vmem_in;
                #1;
                vctrls = '0;
                if (!res.vvalid) begin
                    errors++;
                    $display("%s: no result after %0d cycles", name, edges);
                end
                check_value({name, " stall cycles"}, 160'((vls[k] + 32'd7) / 32'd8),
                            160'(edges));
                check_value({name, " stall gaps"}, 160'(0), 160'(gaps));
                exp    = '0;
                exp[0] = popcount_model(src, m0, me[0], vls[k]);
                compare_result(name, res, exp, 4'b0001);
            end
        end
    endtask

    task automatic output_hold();
        lanes_t    a;
        lanes_t    b;
        vexmem_t   held;
        vexmem_t   exp_held;
        vexmem_t   res;
        vcontrol_t c;
        a = random_lanes();
        b = random_lanes();
        write_reg(3'd4, a);
        write_reg(3'd5, b);
        exp_held            = '0;
        exp_held.vvalid     = 1'b1;
        exp_held.vregwen    = 1'b1;
        exp_held.vd_sel     = 3'd2;
        exp_held.vsew       = SEW32;
        exp_held.vres       = alu_lanes_model(VALU_ADD, SEW32, a, b);
        exp_held.vlane_mask = 4'hf;
        run_op(make_ctrl(VFU_ALU, VALU_ADD, SEW32, 3'd5, 3'd4, 1'b0), held);
        compare_result("stall first op", held, exp_held.vres, 4'hf);
        c            = make_ctrl(VFU_ALU, VALU_XOR, SEW32, 3'd5, 3'd4, 1'b0);
        ex_mem_stall = 1'b1;
        vctrls       = c;
        for (int i = 0; i < 3; i++) begin
            @(posedge CLK);
            #1;
            check_value($sformatf("stall hold cycle %0d", i), 160'(exp_held), 160'(vmem_in));
            #1;
        end
        ex_mem_stall = 1'b0;
        run_op(c, res);
        compare_result("op after stall", res, alu_lanes_model(VALU_XOR, SEW32, a, b), 4'hf);
    endtask

    initial begin
        lfsr_state   = 32'h31d0_6b95;
        errors       = 0;
        checks       = 0;
        rst_n        = 1'b0;
        vctrls       = '0;
        vwb_ctrls    = '0;
        ex_mem_stall = 1'b0;
        vl           = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        rst_n = 1'b1;
        write_read_back();
        elem_width_ops();
        masked_add();
        masked_sum();
        mask_popcount();
        output_hold();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== vex_datapath.f ====
+incdir+include
hw/vex_types_pkg.sv
hw/vex_ctrl_pkg.sv
hw/vex_vector_bank.sv
hw/vex_lane_alu.sv
hw/vex_reduction_unit.sv
hw/vex_scan_counter.sv
hw/vex_mask_calc_fsm.sv
hw/vex_datapath.sv
verification/vex_datapath_asserts.sv
verification/vex_datapath_tb.sv
